// ==== dv/categoryGolden.hex ====
// first value: vector count
// then one vector per line: instruction word, expected category flags
0000001B
00094080 0021 // sll
01494006 0061 // srlv
00004010 0081 // mfhi
01090018 0101 // mult
012A402A 0201 // slt
012A4024 0401 // and
012A4020 0801 // add
29280005 0202 // slti
352800FF 0402 // ori
21280010 0802 // addi
8D280004 1002 // lw
AD280004 2002 // sw
08000010 0006 // j
0C000010 0016 // jal
03E00008 0005 // jr
0120F809 0015 // jalr
11090004 000A // beq
05000008 000A // bltz
05010008 000A // bgez
05100008 001A // bltzal
05110008 001A // bgezal
60000000 0002 // unused opcode 0x18
40800000 0002 // cop0
70000000 0002 // unused opcode 0x1c
FC000000 0002 // unused opcode 0x3f
00094082 0021 // srl
01494004 0061 // sllv

// ==== mipsDecodeUnit.f ====
+incdir+rtl
rtl/mipsDecodePkg.sv
rtl/laneLink.sv
rtl/opFuncCategorizer.sv
rtl/categoryLane.sv
rtl/instrDispatcher.sv
rtl/resultCollector.sv
rtl/mipsDecodeUnit.sv
dv/mipsDecodeUnitTb.sv

// ==== Makefile ====
TOP = mipsDecodeUnitTb
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing -f mipsDecodeUnit.f --top-module $(TOP) -o simv
	-./obj_dir/simv > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Verification passed" $(LOG)

lint:
	verilator --lint-only --timing -f mipsDecodeUnit.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/mipsDecodeUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mipsDecode_config.svh"

module mipsDecodeUnitTb;

	localparam int maxVectors = 64;

	logic clk = 1'b0;
	logic reset;
	logic instrReq;
	logic instrAck;
	mipsDecodePkg::instrWordT instr;
	logic categoryReq;
	logic categoryAck;
	mipsDecodePkg::categoryT category;

	logic [31:0] goldenMem [0:2*maxVectors]; // count, then word/category pairs
	int vectorCount;
	int resultCount = 0;
	int cycleCount = 0;
	int cycleLimit = 100;
	integer seed = 32'h7a86_ce1a;
	logic categoryReqSeen = 1'b0;

	mipsDecodeUnit i_mipsDecodeUnit (
		.clk(clk),
		.reset(reset),
		.instrReq(instrReq),
		.instrAck(instrAck),
		.instr(instr),
		.categoryReq(categoryReq),
		.categoryAck(categoryAck),
		.category(category)
	);

	always #10 clk = ~clk; // 20 ns period

	task automatic reportFailure(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "run stopped at first error");
	endtask

	// all driving and sampling happens 1 ns after the rising edge
	task automatic stepCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic checkCategory(input string testName, input mipsDecodePkg::categoryT expected,
			input mipsDecodePkg::categoryT actual);
		if (actual !== expected) begin
			reportFailure($sformatf("Mismatch %s expected %h actual %h", testName, expected, actual));
		end
	endtask

	task automatic checkLevel(input string testName, input logic expected, input logic actual);
		if (actual !== expected) begin
			reportFailure($sformatf("Mismatch %s expected %b actual %b", testName, expected, actual));
		end
	endtask

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			reportFailure($sformatf("timeout after %0d cycles with %0d of %0d results received",
				cycleCount, resultCount, vectorCount));
		end
	end

	// counts every result offered on the output port, apart from the consumer
	always begin
		stepCycle();
		if (categoryReq && !categoryReqSeen) begin
			resultCount++;
		end
		categoryReqSeen = categoryReq;
	end

	task automatic sendStream();
		for (int idx = 0; idx < vectorCount; idx++) begin
			instr = goldenMem[1 + 2*idx];
			instrReq = 1'b1;
			do stepCycle(); while (!instrAck);
			instrReq = 1'b0;
			do stepCycle(); while (instrAck); // four-phase return to zero
		end
	endtask

	task automatic receiveStream();
		int delay;
		mipsDecodePkg::categoryT expected;
		for (int idx = 0; idx < vectorCount; idx++) begin
			do stepCycle(); while (!categoryReq);
			delay = $unsigned($random(seed)) % 8; // 0 to 7 cycles of back-pressure
			repeat (delay) stepCycle();
			expected = goldenMem[2 + 2*idx][`CAT_WIDTH-1:0];
			checkCategory($sformatf("vector %0d instr %h", idx, goldenMem[1 + 2*idx]),
				expected, category);
			categoryAck = 1'b1;
			do stepCycle(); while (categoryReq);
			categoryAck = 1'b0;
		end
	endtask

	initial begin
		reset = 1'b1;
		instrReq = 1'b0;
		instr = '0;
		categoryAck = 1'b0;
		$readmemh("dv/categoryGolden.hex", goldenMem);
		vectorCount = goldenMem[0];
		if (vectorCount < 1 || vectorCount > maxVectors) begin
			reportFailure("golden file holds no usable vector count");
		end
		cycleLimit = 40 * vectorCount + 100;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (5) begin
			stepCycle();
			checkLevel("idle instrAck", 1'b0, instrAck);
			checkLevel("idle categoryReq", 1'b0, categoryReq);
		end
		fork
			sendStream();
			receiveStream();
		join
		repeat (10) begin
			stepCycle();
			checkLevel("no extra result", 1'b0, categoryReq);
		end
		if (resultCount == vectorCount) begin
			$display("Verification passed");
			$finish;
		end else begin
			reportFailure($sformatf("%0d results came back for %0d vectors", resultCount,
				vectorCount));
		end
	end

endmodule

`default_nettype wire

// ==== rtl/mipsDecodeUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mipsDecode_config.svh"

module mipsDecodeUnit (
	input logic clk,
	input logic reset,
	input logic instrReq,
	output logic instrAck,
	input mipsDecodePkg::instrWordT instr,
	output logic categoryReq,
	input logic categoryAck,
	output mipsDecodePkg::categoryT category
);

	laneLink laneLinks [`DECODE_LANES] ();

	instrDispatcher i_instrDispatcher (
		.clk(clk),
		.reset(reset),
		.instrReq(instrReq),
		.instrAck(instrAck),
		.instr(instr),
		.lanes(laneLinks)
	);

	// one decode lane per link
	genvar i;
	generate
		for (i = 0; i < `DECODE_LANES; i++) begin : gLane
			categoryLane i_categoryLane (
				.clk(clk),
				.reset(reset),
				.link(laneLinks[i])
			);
		end
	endgenerate

	resultCollector i_resultCollector (
		.clk(clk),
		.reset(reset),
		.lanes(laneLinks),
		.categoryReq(categoryReq),
		.categoryAck(categoryAck),
		.category(category)
	);

endmodule

`default_nettype wire

// ==== rtl/resultCollector.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mipsDecode_config.svh"

module resultCollector (
	input logic clk,
	input logic reset,
	laneLink.drain lanes [`DECODE_LANES],
	output logic categoryReq,
	input logic categoryAck,
	output mipsDecodePkg::categoryT category
);

	localparam int laneBits = $clog2(`DECODE_LANES);

	mipsDecodePkg::drainStateT state;
	logic [laneBits-1:0] lanePtr; // steps like the dispatcher pointer
	logic laneAck;
	logic [`DECODE_LANES-1:0] laneReq;
	mipsDecodePkg::categoryT laneCategory [`DECODE_LANES];

	genvar i;
	generate
		for (i = 0; i < `DECODE_LANES; i++) begin : gLane
			assign laneReq[i] = lanes[i].outReq;
			assign laneCategory[i] = lanes[i].category;
			assign lanes[i].outAck = laneAck && (lanePtr == laneBits'(i));
		end
	endgenerate

	always_ff @(posedge clk) begin
		if (state == mipsDecodePkg::drainWait && laneReq[lanePtr]) begin
			category <= laneCategory[lanePtr];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= mipsDecodePkg::drainWait;
			lanePtr <= '0;
			laneAck <= 1'b0;
			categoryReq <= 1'b0;
		end else begin
			case (state)
				mipsDecodePkg::drainWait: begin
					if (laneReq[lanePtr]) begin
						laneAck <= 1'b1;
						state <= mipsDecodePkg::drainPresent;
					end
				end
				mipsDecodePkg::drainPresent: begin
					if (laneAck && !laneReq[lanePtr]) begin
						laneAck <= 1'b0; // lane is free again
					end
					if (!categoryReq) begin
						categoryReq <= 1'b1;
					end else if (categoryAck && !laneAck) begin
						categoryReq <= 1'b0;
						state <= mipsDecodePkg::drainRelease;
					end
				end
				mipsDecodePkg::drainRelease: begin
					if (!categoryAck) begin
						lanePtr <= (lanePtr == laneBits'(`DECODE_LANES - 1)) ?
							'0 : lanePtr + 1'b1;
						state <= mipsDecodePkg::drainWait;
					end
				end
				default: state <= mipsDecodePkg::drainWait;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/instrDispatcher.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mipsDecode_config.svh"

module instrDispatcher (
	input logic clk,
	input logic reset,
	input logic instrReq,
	output logic instrAck,
	input mipsDecodePkg::instrWordT instr,
	laneLink.feeder lanes [`DECODE_LANES]
);

	localparam int laneBits = $clog2(`DECODE_LANES);

	mipsDecodePkg::feedStateT state;
	logic [laneBits-1:0] lanePtr;
	logic laneReq; // inReq of the selected lane
	logic [`DECODE_LANES-1:0] laneAck;
	mipsDecodePkg::instrWordT instrHold;

	genvar i;
	generate
		for (i = 0; i < `DECODE_LANES; i++) begin : gLane
			assign lanes[i].inReq = laneReq && (lanePtr == laneBits'(i));
			assign lanes[i].instr = instrHold;
			assign laneAck[i] = lanes[i].inAck;
		end
	endgenerate

	// word is held here so the lane sees it stable for its whole handshake
	always_ff @(posedge clk) begin
		if (state == mipsDecodePkg::feedWait && instrReq) begin
			instrHold <= instr;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= mipsDecodePkg::feedWait;
			lanePtr <= '0;
			laneReq <= 1'b0;
			instrAck <= 1'b0;
		end else begin
			case (state)
				mipsDecodePkg::feedWait: begin
					if (instrReq && !laneAck[lanePtr]) begin
						laneReq <= 1'b1;
						state <= mipsDecodePkg::feedForward;
					end
				end
				mipsDecodePkg::feedForward: begin
					if (laneAck[lanePtr]) begin
						instrAck <= 1'b1;
					end
					if (instrAck && !instrReq) begin
						laneReq <= 1'b0; // source done, release the lane
						state <= mipsDecodePkg::feedFinish;
					end
				end
				mipsDecodePkg::feedFinish: begin
					if (!laneAck[lanePtr]) begin
						instrAck <= 1'b0;
						lanePtr <= (lanePtr == laneBits'(`DECODE_LANES - 1)) ?
							'0 : lanePtr + 1'b1;
						state <= mipsDecodePkg::feedWait;
					end
				end
				default: state <= mipsDecodePkg::feedWait;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/categoryLane.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mipsDecode_config.svh"

module categoryLane (
	input logic clk,
	input logic reset,
	laneLink.lane link
);

	mipsDecodePkg::laneStateT state;
	mipsDecodePkg::instrWordT instrReg;
	logic [5:0] opcode;
	logic [5:0] funct;
	mipsDecodePkg::opFuncT opFunc;
	mipsDecodePkg::branchOpT branchOp;
	mipsDecodePkg::categoryT categoryNext;
	mipsDecodePkg::categoryT categoryReg;
	logic inAck;
	logic outReq;

	assign opcode = instrReg[`MIPS_INSTR_WIDTH-1 -: 6];
	assign funct = instrReg[5:0];
	assign branchOp = instrReg[20:16]; // rt
	assign opFunc = (opcode == 6'd0) ? {`OPFUNC_SRC_FUNC, funct} : {`OPFUNC_SRC_OP, opcode};

	opFuncCategorizer i_opFuncCategorizer (
		.opFunc(opFunc),
		.branchOp(branchOp),
		.category(categoryNext)
	);

	assign link.inAck = inAck;
	assign link.outReq = outReq;
	assign link.category = categoryReg;

	always_ff @(posedge clk) begin
		if (state == mipsDecodePkg::laneIdle && link.inReq) begin
			instrReg <= link.instr;
		end
		if (state == mipsDecodePkg::laneAccept && !link.inReq) begin
			categoryReg <= categoryNext;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= mipsDecodePkg::laneIdle;
			inAck <= 1'b0;
			outReq <= 1'b0;
		end else begin
			case (state)
				mipsDecodePkg::laneIdle: begin
					if (link.inReq) begin
						inAck <= 1'b1;
						state <= mipsDecodePkg::laneAccept;
					end
				end
				mipsDecodePkg::laneAccept: begin
					if (!link.inReq) begin
						inAck <= 1'b0;
						outReq <= 1'b1; // category registered on this same edge
						state <= mipsDecodePkg::laneOffer;
					end
				end
				mipsDecodePkg::laneOffer: begin
					if (link.outAck) begin
						outReq <= 1'b0;
						state <= mipsDecodePkg::laneRelease;
					end
				end
				mipsDecodePkg::laneRelease: begin
					if (!link.outAck) begin
						state <= mipsDecodePkg::laneIdle;
					end
				end
				default: state <= mipsDecodePkg::laneIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/opFuncCategorizer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mipsDecode_config.svh"

module opFuncCategorizer (
	input mipsDecodePkg::opFuncT opFunc,
	input mipsDecodePkg::branchOpT branchOp,
	output mipsDecodePkg::categoryT category
);

	logic register;
	logic immediate;
	logic jump;
	logic branch;
	logic link;
	logic shift;
	logic shiftV;
	logic hilo;
	logic mulDiv;
	logic compare;
	logic logical;
	logic arithmetic;
	logic load;
	logic store;

	assign register = (opFunc[6] == `OPFUNC_SRC_FUNC);
	assign immediate = (opFunc[6] == `OPFUNC_SRC_OP);

	always_comb begin
		casez (opFunc)
			{`OPFUNC_SRC_FUNC, 6'b001???}: jump = 1'b1; // jr, jalr
			{`OPFUNC_SRC_OP, 6'b00001?}: jump = 1'b1; // j, jal
			default: jump = 1'b0;
		endcase
	end

	always_comb begin
		casez (opFunc)
			{`OPFUNC_SRC_OP, 6'b000001}: branch = 1'b1; // regimm
			{`OPFUNC_SRC_OP, 6'b0001??}: branch = 1'b1;
			default: branch = 1'b0;
		endcase
	end

	always_comb begin
		casez (opFunc)
			{`OPFUNC_SRC_OP, 6'b000011}: link = 1'b1;
			{`OPFUNC_SRC_FUNC, 6'b001001}: link = 1'b1;
			{`OPFUNC_SRC_OP, 6'b000001}: link = branchOp[4]; // bltzal, bgezal
			default: link = 1'b0;
		endcase
	end

	// shifts with a register amount also count as shifts
	always_comb begin
		shift = (opFunc ==? {`OPFUNC_SRC_FUNC, 6'b000???});
		shiftV = (opFunc ==? {`OPFUNC_SRC_FUNC, 6'b0001??});
		hilo = (opFunc ==? {`OPFUNC_SRC_FUNC, 6'b010???});
		mulDiv = (opFunc ==? {`OPFUNC_SRC_FUNC, 6'b011???});
		load = (opFunc ==? {`OPFUNC_SRC_OP, 6'b100???});
		store = (opFunc ==? {`OPFUNC_SRC_OP, 6'b101???});
	end

	always_comb begin
		casez (opFunc)
			{`OPFUNC_SRC_FUNC, 6'b101???}: compare = 1'b1; // slt, sltu
			{`OPFUNC_SRC_OP, 6'b00101?}: compare = 1'b1; // slti, sltiu
			default: compare = 1'b0;
		endcase
	end

	always_comb begin
		casez (opFunc)
			{`OPFUNC_SRC_FUNC, 6'b1001??}: logical = 1'b1;
			{`OPFUNC_SRC_OP, 6'b0011??}: logical = 1'b1;
			default: logical = 1'b0;
		endcase
	end

	always_comb begin
		casez (opFunc)
			{`OPFUNC_SRC_FUNC, 6'b1000??}: arithmetic = 1'b1;
			{`OPFUNC_SRC_OP, 6'b00100?}: arithmetic = 1'b1; // addi, addiu
			default: arithmetic = 1'b0;
		endcase
	end

	assign category[`CAT_REGISTER] = register;
	assign category[`CAT_IMMEDIATE] = immediate;
	assign category[`CAT_JUMP] = jump;
	assign category[`CAT_BRANCH] = branch;
	assign category[`CAT_LINK] = link;
	assign category[`CAT_SHIFT] = shift;
	assign category[`CAT_SHIFTV] = shiftV;
	assign category[`CAT_HILO] = hilo;
	assign category[`CAT_MULDIV] = mulDiv;
	assign category[`CAT_COMPARE] = compare;
	assign category[`CAT_LOGICAL] = logical;
	assign category[`CAT_ARITHMETIC] = arithmetic;
	assign category[`CAT_LOAD] = load;
	assign category[`CAT_STORE] = store;

endmodule

`default_nettype wire

// ==== rtl/laneLink.sv ====
`timescale 1ns/1ps
`default_nettype none

interface laneLink;

	logic inReq; // dispatcher to lane
	mipsDecodePkg::instrWordT instr;
	logic inAck;
	logic outReq; // lane to collector
	mipsDecodePkg::categoryT category;
	logic outAck;

	modport feeder (
		output inReq,
		output instr,
		input inAck
	);

	modport lane (
		input inReq,
		input instr,
		output inAck,
		output outReq,
		output category,
		input outAck
	);

	modport drain (
		input outReq,
		input category,
		output outAck
	);

endinterface

`default_nettype wire

// ==== rtl/mipsDecodePkg.sv ====
`default_nettype none
`include "mipsDecode_config.svh"

package mipsDecodePkg;

	typedef logic [`MIPS_INSTR_WIDTH-1:0] instrWordT;
	typedef logic [6:0] opFuncT; // source bit above the 6-bit code
	typedef logic [4:0] branchOpT; // rt field, REGIMM condition
	typedef logic [`CAT_WIDTH-1:0] categoryT;

	typedef enum logic [1:0] {
		laneIdle,
		laneAccept,
		laneOffer,
		laneRelease
	} laneStateT;

	typedef enum logic [1:0] {
		feedWait,
		feedForward,
		feedFinish
	} feedStateT;

	typedef enum logic [1:0] {
		drainWait,
		drainPresent,
		drainRelease
	} drainStateT;

endpackage

`default_nettype wire

// ==== rtl/mipsDecode_config.svh ====
`ifndef MIPS_DECODE_CONFIG_SVH
`define MIPS_DECODE_CONFIG_SVH

`define MIPS_INSTR_WIDTH 32
`define DECODE_LANES 4 // two or more

// opFunc source bit
`define OPFUNC_SRC_FUNC 1'b1 // code is the function field
`define OPFUNC_SRC_OP 1'b0 // code is the opcode field

`define CAT_REGISTER 0
`define CAT_IMMEDIATE 1
`define CAT_JUMP 2
`define CAT_BRANCH 3
`define CAT_LINK 4
`define CAT_SHIFT 5
`define CAT_SHIFTV 6
`define CAT_HILO 7
`define CAT_MULDIV 8
`define CAT_COMPARE 9
`define CAT_LOGICAL 10
`define CAT_ARITHMETIC 11
`define CAT_LOAD 12
`define CAT_STORE 13
`define CAT_WIDTH 14

`endif
